/* design/xbar_pkg.sv */
// --------------------
// AXI read crossbar shared types
// --------------------
package xbar_pkg;

    // --------------------
    // bus widths
    // --------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;                 // AXI4 arlen

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [1:0]        resp_t;

    // --------------------
    // response codes
    // --------------------
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;   // no window hit

    // AR payload, 49 bits
    typedef struct packed {
        id_t        id;
        addr_t      addr;
        len_t       len;
        logic [2:0] size;
        logic [1:0] burst;
    } ar_info_t;

    // R payload, 39 bits
    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_info_t;

endpackage

/* design/rd_route_if.sv */
`timescale 1ns/1ps
// --------------------
// Read routing control bundle
// --------------------
interface rd_route_if import xbar_pkg::*; #(
    parameter int NUM_PORTS = 4
) ();

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [IDX_W-1:0] req_target;   // decoded port
    logic             req_decerr;
    logic             req_valid;
    logic             issue_ok;
    logic             issue;        // upstream AR handshake
    logic [IDX_W-1:0] cur_target;   // locked port
    logic             err_mode;
    logic             burst_done;   // R handshake with last
    logic             beat_done;    // any R handshake
    logic             cnt_zero;
    logic             cnt_full;
    len_t             err_len;
    logic             err_last;

    modport router  (output req_target, req_decerr, req_valid, issue, err_len,
                     input issue_ok);
    modport fsm     (input req_target, req_decerr, req_valid, issue, burst_done,
                     cnt_zero, cnt_full, output issue_ok, cur_target, err_mode);
    modport counter (input issue, req_decerr, burst_done, beat_done, err_mode, err_len,
                     output cnt_zero, cnt_full, err_last);
    modport mux     (input cur_target, err_mode, cnt_zero, err_last, issue, req_decerr,
                     output burst_done, beat_done);

endinterface

/* design/ar_router.sv */
`timescale 1ns/1ps
// --------------------
// AR decode and steering
// --------------------
module ar_router import xbar_pkg::*; #(
    parameter int                          NUM_PORTS = 4,
    parameter logic [NUM_PORTS*ADDR_W-1:0] ADDR_BASE = '0,
    parameter logic [NUM_PORTS*ADDR_W-1:0] ADDR_HIGH = '0
) (
    input  ar_info_t             s_ar,
    input  logic                 s_arvalid,
    output logic                 s_arready,
    output ar_info_t             m_ar [NUM_PORTS],
    output logic [NUM_PORTS-1:0] m_arvalid,
    input  logic [NUM_PORTS-1:0] m_arready,
    rd_route_if.router           rt
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [IDX_W-1:0] target;
    logic             hit;

    // scan high to low so the lowest match is kept
    always_comb begin
        hit    = 1'b0;
        target = '0;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            if (s_ar.addr >= ADDR_BASE[i*ADDR_W +: ADDR_W] &&
                s_ar.addr <= ADDR_HIGH[i*ADDR_W +: ADDR_W]) begin
                hit    = 1'b1;
                target = IDX_W'(i);
            end
        end
    end

    assign rt.req_target = target;
    assign rt.req_decerr = ~hit;
    assign rt.req_valid  = s_arvalid;
    assign rt.err_len    = s_ar.len;                 // beat count for DECERR

    // unmapped requests are taken locally without a downstream ready
    assign s_arready = rt.issue_ok & (~hit | m_arready[target]);
    assign rt.issue  = s_arvalid & s_arready;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            m_ar[i]      = s_ar;                     // payload to every port
            m_arvalid[i] = s_arvalid & rt.issue_ok & hit & (target == IDX_W'(i));
        end
    end

endmodule

/* design/rd_route_fsm.sv */
`timescale 1ns/1ps
// --------------------
// Target lock FSM
// --------------------
module rd_route_fsm #(
    parameter int NUM_PORTS = 4
) (
    input  logic     clk_sys,
    input  logic     arst_n,
    rd_route_if.fsm  rt
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;     // target locked
    localparam logic [1:0] ST_ERR  = 2'd2;     // DECERR beats going out

    logic [1:0]       state;
    logic [1:0]       state_nxt;
    logic [IDX_W-1:0] target_q;
    logic             same_target;

    assign same_target = ~rt.req_decerr & (rt.req_target == target_q);

    // --------------------
    // issue gate
    // --------------------
    always_comb begin
        case (state)
            ST_IDLE: rt.issue_ok = rt.req_valid;
            ST_BUSY: rt.issue_ok = rt.req_valid & same_target & ~rt.cnt_full;
            default: rt.issue_ok = 1'b0;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (rt.issue) begin
                    state_nxt = rt.req_decerr ? ST_ERR : ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (rt.cnt_zero && !rt.issue) begin
                    state_nxt = ST_IDLE;              // drained
                end
            end
            ST_ERR: begin
                if (rt.burst_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            target_q <= '0;
        end else begin
            state <= state_nxt;
            if (rt.issue && state == ST_IDLE) begin
                target_q <= rt.req_target;            // lock on first burst
            end
        end
    end

    assign rt.cur_target = target_q;
    assign rt.err_mode   = (state == ST_ERR);

    // DECERR beats never share the R channel with routed bursts
    a_err_drained: assert property (@(posedge clk_sys) disable iff (!arst_n)
        rt.err_mode |-> rt.cnt_zero);

endmodule

/* design/rd_txn_counter.sv */
`timescale 1ns/1ps
// --------------------
// Outstanding burst counter
// --------------------
module rd_txn_counter import xbar_pkg::*; #(
    parameter int NUM_OUTSTANDING = 4
) (
    input  logic        clk_sys,
    input  logic        arst_n,
    rd_route_if.counter rt
);

    localparam int CNT_W = $clog2(NUM_OUTSTANDING + 1);

    logic [CNT_W-1:0] cnt;
    len_t             err_cnt;
    logic             inc;
    logic             dec;

    assign inc = rt.issue & ~rt.req_decerr;        // routed bursts only
    assign dec = rt.burst_done & ~rt.err_mode;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (inc && !dec) begin
            cnt <= cnt + 1'b1;
        end else if (dec && !inc) begin
            cnt <= cnt - 1'b1;
        end
    end

    // --------------------
    // DECERR beat countdown
    // --------------------
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            err_cnt <= '0;
        end else if (rt.issue && rt.req_decerr) begin
            err_cnt <= rt.err_len;
        end else if (rt.beat_done && rt.err_mode && err_cnt != '0) begin
            err_cnt <= err_cnt - 1'b1;
        end
    end

    assign rt.cnt_zero = (cnt == '0);
    assign rt.cnt_full = (cnt == CNT_W'(NUM_OUTSTANDING));
    assign rt.err_last = (err_cnt == '0);

    a_no_inc_full: assert property (@(posedge clk_sys) disable iff (!arst_n)
        inc |-> !rt.cnt_full);

    // R last with nothing outstanding means a stray burst downstream
    a_no_dec_zero: assert property (@(posedge clk_sys) disable iff (!arst_n)
        dec |-> !rt.cnt_zero);

endmodule

/* design/r_return_mux.sv */
`timescale 1ns/1ps
// --------------------
// R return path
// --------------------
module r_return_mux import xbar_pkg::*; #(
    parameter int NUM_PORTS = 4
) (
    input  logic                 clk_sys,
    input  logic                 arst_n,
    output r_info_t              s_r,
    output logic                 s_rvalid,
    input  logic                 s_rready,
    input  r_info_t              m_r [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] m_rvalid,
    output logic [NUM_PORTS-1:0] m_rready,
    input  id_t                  err_id,
    rd_route_if.mux              rt
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    id_t     err_id_q;
    r_info_t err_beat;
    logic    route_en;

    always_ff @(posedge clk_sys) begin
        if (rt.issue && rt.req_decerr) begin
            err_id_q <= err_id;                   // arid of the unmapped request
        end
    end

    assign err_beat = '{id: err_id_q, data: '0, resp: RESP_DECERR, last: rt.err_last};

    // only while bursts are outstanding to the locked port
    assign route_en = ~rt.cnt_zero & ~rt.err_mode;

    assign s_r      = rt.err_mode ? err_beat : m_r[rt.cur_target];
    assign s_rvalid = rt.err_mode | (route_en & m_rvalid[rt.cur_target]);

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            m_rready[i] = route_en & s_rready & (rt.cur_target == IDX_W'(i));
        end
    end

    assign rt.beat_done  = s_rvalid & s_rready;
    assign rt.burst_done = rt.beat_done & s_r.last;

    // stalled beat stays put, routed or local
    a_r_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_r));

endmodule

/* design/axi_rd_xbar_top.sv */
`timescale 1ns/1ps
// --------------------
// AXI4 read crossbar, 1 to N
// --------------------
module axi_rd_xbar_top import xbar_pkg::*; #(
    parameter int NUM_PORTS       = 4,                  // 1 ~ 4
    parameter int NUM_OUTSTANDING = 4,
    parameter logic [NUM_PORTS*ADDR_W-1:0] ADDR_BASE = {32'h3000_0000, 32'h2000_0000,
                                                        32'h1000_0000, 32'h0000_0000},
    parameter logic [NUM_PORTS*ADDR_W-1:0] ADDR_HIGH = {32'h3000_ffff, 32'h2000_ffff,
                                                        32'h1000_ffff, 32'h0000_ffff}
) (
    input  logic                        clk_sys,
    input  logic                        arst_n,
    // upstream AR
    input  id_t                         s_arid,
    input  addr_t                       s_araddr,
    input  len_t                        s_arlen,
    input  logic [2:0]                  s_arsize,
    input  logic [1:0]                  s_arburst,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    // upstream R
    output id_t                         s_rid,
    output data_t                       s_rdata,
    output resp_t                       s_rresp,
    output logic                        s_rlast,
    output logic                        s_rvalid,
    input  logic                        s_rready,
    // downstream AR, packed per port
    output logic [NUM_PORTS*ID_W-1:0]   m_arid,
    output logic [NUM_PORTS*ADDR_W-1:0] m_araddr,
    output logic [NUM_PORTS*LEN_W-1:0]  m_arlen,
    output logic [NUM_PORTS*3-1:0]      m_arsize,
    output logic [NUM_PORTS*2-1:0]      m_arburst,
    output logic [NUM_PORTS-1:0]        m_arvalid,
    input  logic [NUM_PORTS-1:0]        m_arready,
    // downstream R, packed per port
    input  logic [NUM_PORTS*ID_W-1:0]   m_rid,
    input  logic [NUM_PORTS*DATA_W-1:0] m_rdata,
    input  logic [NUM_PORTS*2-1:0]      m_rresp,
    input  logic [NUM_PORTS-1:0]        m_rlast,
    input  logic [NUM_PORTS-1:0]        m_rvalid,
    output logic [NUM_PORTS-1:0]        m_rready
);

    ar_info_t s_ar;
    ar_info_t m_ar [NUM_PORTS];
    r_info_t  s_r;
    r_info_t  m_r  [NUM_PORTS];

    rd_route_if #(.NUM_PORTS(NUM_PORTS)) rt ();

    // --------------------
    // field packing
    // --------------------
    assign s_ar = '{id: s_arid, addr: s_araddr, len: s_arlen,
                    size: s_arsize, burst: s_arburst};

    assign s_rid   = s_r.id;
    assign s_rdata = s_r.data;
    assign s_rresp = s_r.resp;
    assign s_rlast = s_r.last;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign m_arid[i*ID_W +: ID_W]       = m_ar[i].id;
        assign m_araddr[i*ADDR_W +: ADDR_W] = m_ar[i].addr;
        assign m_arlen[i*LEN_W +: LEN_W]    = m_ar[i].len;
        assign m_arsize[i*3 +: 3]           = m_ar[i].size;
        assign m_arburst[i*2 +: 2]          = m_ar[i].burst;
        assign m_r[i] = '{id: m_rid[i*ID_W +: ID_W], data: m_rdata[i*DATA_W +: DATA_W],
                          resp: m_rresp[i*2 +: 2], last: m_rlast[i]};
    end

    // --------------------
    // instances
    // --------------------
    ar_router #(
        .NUM_PORTS (NUM_PORTS),
        .ADDR_BASE (ADDR_BASE),
        .ADDR_HIGH (ADDR_HIGH)
    ) u_ar_router (
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .rt        (rt.router)
    );

    rd_route_fsm #(.NUM_PORTS(NUM_PORTS)) u_rd_route_fsm (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .rt      (rt.fsm)
    );

    rd_txn_counter #(.NUM_OUTSTANDING(NUM_OUTSTANDING)) u_rd_txn_counter (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .rt      (rt.counter)
    );

    r_return_mux #(.NUM_PORTS(NUM_PORTS)) u_r_return_mux (
        .clk_sys  (clk_sys),
        .arst_n   (arst_n),
        .s_r      (s_r),
        .s_rvalid (s_rvalid),
        .s_rready (s_rready),
        .m_r      (m_r),
        .m_rvalid (m_rvalid),
        .m_rready (m_rready),
        .err_id   (s_arid),          // held with the DECERR AR
        .rt       (rt.mux)
    );

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/1ps
// --------------------
// Upstream read checker
// --------------------
module tb_checker import xbar_pkg::*; #(
    parameter int NUM_PORTS       = 4,
    parameter int NUM_OUTSTANDING = 4
) (
    input logic                        clk_sys,
    input logic                        arst_n,
    input logic [2:0]                  s_arsize,
    input logic [1:0]                  s_arburst,
    input logic                        s_arvalid,
    input logic                        s_arready,
    input id_t                         s_rid,
    input data_t                       s_rdata,
    input resp_t                       s_rresp,
    input logic                        s_rlast,
    input logic                        s_rvalid,
    input logic                        s_rready,
    input logic [NUM_PORTS*ID_W-1:0]   m_arid,
    input logic [NUM_PORTS*ADDR_W-1:0] m_araddr,
    input logic [NUM_PORTS*LEN_W-1:0]  m_arlen,
    input logic [NUM_PORTS*3-1:0]      m_arsize,
    input logic [NUM_PORTS*2-1:0]      m_arburst,
    input logic [NUM_PORTS-1:0]        m_arvalid,
    input logic [NUM_PORTS-1:0]        m_rready
);

    typedef struct packed {
        id_t        id;
        addr_t      addr;
        len_t       len;
        logic [2:0] port;     // 4 is DECERR
        resp_t      resp;
    } exp_t;

    exp_t        exp_q [$];      // driven, not yet accepted
    exp_t        burst_q [$];    // accepted, R pending
    int          beat;
    int          errors;
    int          bursts_done;
    int          burst_errs;
    logic        held;
    logic [38:0] held_r;

    initial begin
        beat        = 0;
        errors      = 0;
        bursts_done = 0;
        burst_errs  = 0;
        held        = 1'b0;
        held_r      = '0;
    end

    function automatic void push_expected(id_t id, addr_t addr, len_t len,
                                          logic [2:0] port, resp_t resp);
        exp_t e;
        e = '{id: id, addr: addr, len: len, port: port, resp: resp};
        exp_q.push_back(e);
    endfunction

    function automatic int pending();
        return exp_q.size() + burst_q.size();
    endfunction

    function automatic void check_val(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
            burst_errs++;
        end
    endfunction

    function automatic void complain(string what);
        $display("error at %0t: %s", $time, what);
        errors++;
        burst_errs++;
    endfunction

    always @(posedge clk_sys) begin
        exp_t       e;
        exp_t       b;
        addr_t      a;
        logic [31:0] exp_data;
        logic [NUM_PORTS-1:0] exp_rready;
        int         p;
        if (arst_n) begin
            // --------------------
            // R side
            // --------------------
            if (held && (!s_rvalid || held_r !== {s_rid, s_rdata, s_rresp, s_rlast})) begin
                complain("stalled R beat changed or dropped");
            end
            held   = s_rvalid && !s_rready;
            held_r = {s_rid, s_rdata, s_rresp, s_rlast};

            // ready only toward the port that owns the oldest routed burst
            exp_rready = '0;
            if (burst_q.size() > 0 && burst_q[0].port != 3'd4) begin
                exp_rready[int'(burst_q[0].port)] = s_rready;
            end
            check_val("m_rready", 32'(exp_rready), 32'(m_rready));

            if (s_rvalid && burst_q.size() == 0) begin
                complain("s_rvalid high with no burst outstanding");
            end else if (s_rvalid && s_rready) begin
                b = burst_q[0];
                a = b.addr + 32'(4 * beat);
                exp_data = (b.port == 3'd4) ? 32'h0 : {8'(b.port), a[23:0]};
                check_val("s_rid", 32'(b.id), 32'(s_rid));
                check_val("s_rdata", exp_data, s_rdata);
                check_val("s_rresp", 32'(b.resp), 32'(s_rresp));
                check_val("s_rlast", 32'(beat == int'(b.len)), 32'(s_rlast));
                if (beat == int'(b.len)) begin
                    void'(burst_q.pop_front());
                    bursts_done++;
                    $display("burst %0d id %h port %0d, %0d beats: %s", bursts_done, b.id,
                             b.port, b.len + 1, (burst_errs == 0) ? "ok" : "errors");
                    burst_errs = 0;
                    beat       = 0;
                end else begin
                    beat++;
                end
            end

            // --------------------
            // AR side
            // --------------------
            if (!s_arvalid && m_arvalid != '0) begin
                complain("m_arvalid high without an upstream request");
            end
            if (s_arvalid && s_arready) begin
                if (exp_q.size() == 0) begin
                    complain("AR accepted with no request expected");
                end else begin
                    e = exp_q.pop_front();
                    if (e.port == 3'd4) begin
                        check_val("m_arvalid", 32'h0, 32'(m_arvalid));
                    end else begin
                        p = int'(e.port);
                        check_val("m_arvalid", 32'(1) << p, 32'(m_arvalid));
                        check_val("m_arid", 32'(e.id), 32'(m_arid[p*ID_W +: ID_W]));
                        check_val("m_araddr", e.addr, m_araddr[p*ADDR_W +: ADDR_W]);
                        check_val("m_arlen", 32'(e.len), 32'(m_arlen[p*LEN_W +: LEN_W]));
                        check_val("m_arsize", 32'(s_arsize), 32'(m_arsize[p*3 +: 3]));
                        check_val("m_arburst", 32'(s_arburst), 32'(m_arburst[p*2 +: 2]));
                    end
                    foreach (burst_q[i]) begin
                        if (burst_q[i].port != e.port || e.port == 3'd4) begin
                            complain("target changed while bursts were outstanding");
                            break;
                        end
                    end
                    if (burst_q.size() >= NUM_OUTSTANDING) begin
                        complain("more bursts in flight than allowed");
                    end
                    burst_q.push_back(e);
                end
            end
        end
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps
// --------------------
// AXI read crossbar testbench
// --------------------
module tb_top import xbar_pkg::*;;

    localparam int NUM_PORTS       = 4;
    localparam int NUM_OUTSTANDING = 4;
    localparam int AR_TIMEOUT      = 300;
    localparam int DRAIN_TIMEOUT   = 3000;

    logic clk_sys;
    logic arst_n;
    id_t  s_arid;
    addr_t s_araddr;
    len_t s_arlen;
    logic [2:0] s_arsize;
    logic [1:0] s_arburst;
    logic s_arvalid;
    logic s_arready;
    id_t  s_rid;
    data_t s_rdata;
    resp_t s_rresp;
    logic s_rlast;
    logic s_rvalid;
    logic s_rready;
    logic [NUM_PORTS*ID_W-1:0]   m_arid;
    logic [NUM_PORTS*ADDR_W-1:0] m_araddr;
    logic [NUM_PORTS*LEN_W-1:0]  m_arlen;
    logic [NUM_PORTS*3-1:0]      m_arsize;
    logic [NUM_PORTS*2-1:0]      m_arburst;
    logic [NUM_PORTS-1:0]        m_arvalid;
    logic [NUM_PORTS-1:0]        m_arready;
    logic [NUM_PORTS*ID_W-1:0]   m_rid;
    logic [NUM_PORTS*DATA_W-1:0] m_rdata;
    logic [NUM_PORTS*2-1:0]      m_rresp;
    logic [NUM_PORTS-1:0]        m_rlast;
    logic [NUM_PORTS-1:0]        m_rvalid;
    logic [NUM_PORTS-1:0]        m_rready;

    logic [31:0] lfsr;
    logic        aborted;
    logic [43:0] rsp_q [NUM_PORTS][$];   // {id, addr, len} per accepted AR
    int          rsp_beat [NUM_PORTS];

    axi_rd_xbar_top #(
        .NUM_PORTS       (NUM_PORTS),
        .NUM_OUTSTANDING (NUM_OUTSTANDING)
    ) dut (.*);

    tb_checker #(
        .NUM_PORTS       (NUM_PORTS),
        .NUM_OUTSTANDING (NUM_OUTSTANDING)
    ) chk (.*);

    // one bit per step, Galois form
    function automatic logic rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // --------------------
    // downstream responders
    // --------------------
    initial begin
        logic [43:0] r;
        addr_t       a;
        logic [NUM_PORTS-1:0] taken;
        m_arready = '0;
        m_rid     = '0;
        m_rdata   = '0;
        m_rresp   = '0;
        m_rlast   = '0;
        m_rvalid  = '0;
        s_rready  = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rsp_beat[p] = 0;
        end
        forever begin
            @(posedge clk_sys);
            for (int p = 0; p < NUM_PORTS; p++) begin
                taken[p] = m_rvalid[p] & m_rready[p];
                if (m_arvalid[p] && m_arready[p]) begin
                    rsp_q[p].push_back({m_arid[p*ID_W +: ID_W], m_araddr[p*ADDR_W +: ADDR_W],
                                        m_arlen[p*LEN_W +: LEN_W]});
                end
                if (taken[p]) begin
                    if (m_rlast[p]) begin
                        void'(rsp_q[p].pop_front());
                        rsp_beat[p] = 0;
                    end else begin
                        rsp_beat[p]++;
                    end
                end
            end
            #2;
            for (int p = 0; p < NUM_PORTS; p++) begin
                m_arready[p] = rand_bit() | rand_bit();   // stall about 1 in 4
                if (!m_rvalid[p] || taken[p]) begin
                    m_rvalid[p] = 1'b0;
                    if (rsp_q[p].size() > 0) begin
                        r = rsp_q[p][0];
                        a = r[39:8] + 32'(4 * rsp_beat[p]);
                        m_rid[p*ID_W +: ID_W]       = r[43:40];
                        m_rdata[p*DATA_W +: DATA_W] = {8'(p), a[23:0]};
                        m_rresp[p*2 +: 2]           = RESP_OKAY;
                        m_rlast[p]                  = (rsp_beat[p] == int'(r[7:0]));
                        m_rvalid[p]                 = 1'b1;
                    end
                end
            end
            s_rready = rand_bit() | rand_bit();
        end
    end

    task automatic drive_request(id_t id, addr_t addr, len_t len, logic [2:0] port,
                                 resp_t resp);
        int waited;
        s_arid    = id;
        s_araddr  = addr;
        s_arlen   = len;
        s_arvalid = 1'b1;
        chk.push_expected(id, addr, len, port, resp);
        waited = 0;
        do begin
            @(posedge clk_sys);
            waited++;
        end while (!s_arready && waited < AR_TIMEOUT);
        if (!s_arready) begin
            $display("timeout: AR with id %h address %h was never accepted", id, addr);
            aborted = 1'b1;
        end
        #2;
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int          fd;
        int          n;
        int          waited;
        string       line;
        logic [31:0] f_id, f_addr, f_len, f_port, f_resp;
        lfsr      = 32'hde3c3219;
        aborted   = 1'b0;
        arst_n    = 1'b0;
        s_arid    = '0;
        s_araddr  = '0;
        s_arlen   = '0;
        s_arsize  = 3'd2;
        s_arburst = 2'd1;
        s_arvalid = 1'b0;
        repeat (4) @(posedge clk_sys);
        #2;
        arst_n = 1'b1;
        repeat (6) @(posedge clk_sys);   // idle, checker watches for stray valids
        #2;
        fd = $fopen("dv/xbar_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/xbar_stimulus.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                if (line.len() == 0 || line.getc(0) == 8'h23) begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h", f_id, f_addr, f_len, f_port, f_resp);
                if (n != 5) begin
                    continue;
                end
                drive_request(id_t'(f_id), f_addr, len_t'(f_len), 3'(f_port),
                              resp_t'(f_resp));
            end
            $fclose(fd);
        end
        s_arvalid = 1'b0;
        waited = 0;
        while (!aborted && chk.pending() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk_sys);
            waited++;
        end
        if (!aborted && chk.pending() != 0) begin
            $display("timeout: %0d bursts never completed", chk.pending());
            aborted = 1'b1;
        end
        $display("bursts completed %0d, errors %0d", chk.bursts_done, chk.errors);
        if (aborted || chk.errors != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

/* list.f */
design/xbar_pkg.sv
design/rd_route_if.sv
design/ar_router.sv
design/rd_route_fsm.sv
design/rd_txn_counter.sv
design/r_return_mux.sv
design/axi_rd_xbar_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the AXI read crossbar testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_top -o sim_tb_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
    exit 0
else
    exit 1
fi

/* dv/xbar_stimulus.txt */
# arid araddr arlen port resp   (hex; port 4 means DECERR)
# one AR request per line, issued in order
1 00000010 3 0 0
2 00000100 0 0 0
3 10000020 1 1 0
4 1000ff00 2 1 0
5 20000000 1 2 0
6 20000040 0 2 0
7 20000080 2 2 0
8 200000c0 3 2 0
9 20000100 1 2 0
a 40000000 2 4 3
b 00010000 0 4 3
c 3000fffc 0 3 0
d 30000000 4 3 0
e 00000200 1 0 0
f 2fffffff 1 4 3
0 10000000 7 1 0
1 1000fffc 0 1 0
2 ffffffff 3 4 3
